// File: rtl/rbt_params.svh
// stream, FIFO, flow table and register bus sizes, scratch reset value
`ifndef RBT_PARAMS_SVH
`define RBT_PARAMS_SVH

// stream word
`define RBT_DATA_W 64
`define RBT_KEEP_W 8
`define RBT_USER_W 16

// buffering and flow table
`define RBT_FIFO_DEPTH 32
`define RBT_FLOW_COUNT 16

// register bus
`define RBT_CSR_ADDR_W 16
`define RBT_CSR_DATA_W 32
`define RBT_SCRATCH_RESET 32'h12345678

`endif

// File: rtl/rbt_pkt_pkg.sv
// packet header struct, header/raw beat union, flow and sequence types
`default_nettype none
`include "rbt_params.svh"

package rbt_pkt_pkg;

    typedef logic [15:0] rbt_seq_t;
    typedef logic [$clog2(`RBT_FLOW_COUNT)-1:0] rbt_flow_t;

    // retransmit flag position inside flags
    localparam int RBT_FLAG_RETX = 0;

    typedef struct packed {
        logic [15:0] reserved;
        logic [15:0] length;
        rbt_seq_t    seq;
        logic [7:0]  flags;
        logic [7:0]  flow_id;
    } rbt_hdr_t;

    // first beat of a frame read as header
    typedef union packed {
        logic [`RBT_DATA_W-1:0] raw;
        rbt_hdr_t               hdr;
    } rbt_beat_u;

endpackage

`default_nettype wire

// File: rtl/rbt_csr_pkg.sv
// register address map and register word type
`default_nettype none
`include "rbt_params.svh"

package rbt_csr_pkg;

    typedef enum logic [`RBT_CSR_ADDR_W-1:0] {
        SCRATCH   = 16'h0000,
        CLEAR     = 16'h0004,
        IN_COUNT  = 16'h0010,
        IN_USER   = 16'h0014,
        OUT_COUNT = 16'h0018,
        OUT_USER  = 16'h001C
    } csr_addr_e;

    typedef logic [`RBT_CSR_DATA_W-1:0] csr_word_t;

endpackage

`default_nettype wire

// File: rtl/axis_if.sv
// stream interface with source, sink and monitor modports
`default_nettype none
`include "rbt_params.svh"

interface axis_if;
    logic [`RBT_DATA_W-1:0] tdata;
    logic [`RBT_KEEP_W-1:0] tkeep;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    logic [`RBT_USER_W-1:0] tuser;

    modport source (output tdata, tkeep, tvalid, tlast, tuser, input tready);

    modport sink (input tdata, tkeep, tvalid, tlast, tuser, output tready);

    modport monitor (input tdata, tkeep, tvalid, tready, tlast, tuser);
endinterface

`default_nettype wire

// File: rtl/rbt_parser.sv
// parser that decodes the header beat and forwards all beats to the FIFO
`default_nettype none

module rbt_parser
    import rbt_pkt_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    axis_if.sink     in_bus,
    axis_if.source   fifo_bus,
    output rbt_hdr_t hdr,
    output logic     hdr_valid,
    input  logic     hdr_ready
);

    logic      first_beat;
    logic      beat_ok;
    logic      accept;
    rbt_beat_u in_beat;

    // a first beat has to wait for the header register to empty
    assign beat_ok = !first_beat || !hdr_valid;
    assign in_bus.tready = fifo_bus.tready && beat_ok;
    assign accept = in_bus.tvalid && in_bus.tready;

    assign fifo_bus.tvalid = in_bus.tvalid && beat_ok;
    assign fifo_bus.tdata = in_bus.tdata;
    assign fifo_bus.tkeep = in_bus.tkeep;
    assign fifo_bus.tlast = in_bus.tlast;
    assign fifo_bus.tuser = in_bus.tuser;

    assign in_beat.raw = in_bus.tdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            hdr_valid <= 1'b0;
        end else begin
            if (accept) begin
                first_beat <= in_bus.tlast;
            end
            if (accept && first_beat) begin
                hdr_valid <= 1'b1;
            end else if (hdr_ready) begin
                hdr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && first_beat) begin
            hdr <= in_beat.hdr;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbt_frame_fifo.sv
// beat FIFO holding frames while their headers are stamped
`default_nettype none
`include "rbt_params.svh"

module rbt_frame_fifo (
    input  logic   clk,
    input  logic   rst,
    axis_if.sink   wr_bus,
    axis_if.source rd_bus
);

    localparam int DEPTH = `RBT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int WORD_W = `RBT_DATA_W + `RBT_KEEP_W + 1 + `RBT_USER_W;

    logic [WORD_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              push;
    logic              pop;

    assign wr_bus.tready = (count != DEPTH[PTR_W:0]);
    assign rd_bus.tvalid = (count != '0);

    assign push = wr_bus.tvalid && wr_bus.tready;
    assign pop = rd_bus.tvalid && rd_bus.tready;

    // head of queue read straight from the array
    assign {rd_bus.tdata, rd_bus.tkeep, rd_bus.tlast, rd_bus.tuser} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_bus.tdata, wr_bus.tkeep, wr_bus.tlast, wr_bus.tuser};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbt_seq_stamper.sv
// per-flow sequence counters that stamp or keep the header sequence number
`default_nettype none
`include "rbt_params.svh"

module rbt_seq_stamper
    import rbt_pkt_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  rbt_hdr_t in_hdr,
    input  logic     in_valid,
    output logic     in_ready,
    output rbt_hdr_t out_hdr,
    output logic     out_valid,
    input  logic     out_ready
);

    rbt_seq_t  seq_ctr [`RBT_FLOW_COUNT];
    rbt_flow_t flow;
    logic      retx;
    logic      take;

    assign in_ready = !out_valid || out_ready;
    assign take = in_valid && in_ready;
    assign flow = in_hdr.flow_id[$bits(rbt_flow_t)-1:0];
    assign retx = in_hdr.flags[RBT_FLAG_RETX];

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            for (int i = 0; i < `RBT_FLOW_COUNT; i++) begin
                seq_ctr[i] <= '0;
            end
        end else begin
            if (take) begin
                out_valid <= 1'b1;
                // retransmits reuse their number and leave the counter alone
                if (!retx) begin
                    seq_ctr[flow] <= seq_ctr[flow] + 1'b1;
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_hdr <= in_hdr;
            if (!retx) begin
                out_hdr.seq <= seq_ctr[flow];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbt_deparser.sv
// deparser that writes the stamped header over each frame's first beat
`default_nettype none

module rbt_deparser
    import rbt_pkt_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    axis_if.sink     fifo_bus,
    input  rbt_hdr_t hdr,
    input  logic     hdr_valid,
    output logic     hdr_ready,
    axis_if.source   out_bus
);

    logic      first_beat;
    logic      beat_ok;
    logic      move;
    rbt_beat_u out_beat;

    // first beat held back until its header is ready
    assign beat_ok = !first_beat || hdr_valid;

    assign out_bus.tvalid = fifo_bus.tvalid && beat_ok;
    assign fifo_bus.tready = out_bus.tready && beat_ok;
    assign move = out_bus.tvalid && out_bus.tready;

    assign hdr_ready = first_beat && fifo_bus.tvalid && out_bus.tready;

    always_comb begin
        out_beat.raw = fifo_bus.tdata;
        if (first_beat) begin
            out_beat.hdr = hdr;
        end
    end

    assign out_bus.tdata = out_beat.raw;
    assign out_bus.tkeep = fifo_bus.tkeep;
    assign out_bus.tlast = fifo_bus.tlast;
    assign out_bus.tuser = fifo_bus.tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
        end else if (move) begin
            first_beat <= out_bus.tlast;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbt_csr_regs.sv
// control/status registers with scratch, clear, frame counters and register bus access
`default_nettype none
`include "rbt_params.svh"

module rbt_csr_regs
    import rbt_csr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    axis_if.monitor                    in_mon,
    axis_if.monitor                    out_mon,
    input  logic [`RBT_CSR_ADDR_W-1:0] wr_addr,
    input  csr_word_t                  wr_data,
    input  logic                       wr_en,
    output logic                       wr_ack,
    input  logic [`RBT_CSR_ADDR_W-1:0] rd_addr,
    input  logic                       rd_en,
    output csr_word_t                  rd_data,
    output logic                       rd_ack
);

    csr_addr_e              wr_word;
    csr_addr_e              rd_word;
    logic                   wr_go;
    logic                   rd_go;
    logic                   clear_hit;
    csr_word_t              rd_mux;
    csr_word_t              scratch;
    csr_word_t              in_count;
    csr_word_t              out_count;
    logic [`RBT_USER_W-1:0] in_user;
    logic [`RBT_USER_W-1:0] out_user;

    function automatic logic is_mapped(input csr_addr_e addr);
        case (addr)
            SCRATCH, CLEAR, IN_COUNT, IN_USER, OUT_COUNT, OUT_USER: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // byte offset within a word is ignored
    assign wr_word = csr_addr_e'({wr_addr[`RBT_CSR_ADDR_W-1:2], 2'b00});
    assign rd_word = csr_addr_e'({rd_addr[`RBT_CSR_ADDR_W-1:2], 2'b00});

    // a held enable is served every other cycle
    assign wr_go = wr_en && !wr_ack;
    assign rd_go = rd_en && !rd_ack;
    assign clear_hit = wr_go && (wr_word == CLEAR) && wr_data[0];

    always_comb begin
        case (rd_word)
            SCRATCH:   rd_mux = scratch;
            IN_COUNT:  rd_mux = in_count;
            IN_USER:   rd_mux = csr_word_t'(in_user);
            OUT_COUNT: rd_mux = out_count;
            OUT_USER:  rd_mux = csr_word_t'(out_user);
            default:   rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
            rd_data <= '0;
            scratch <= `RBT_SCRATCH_RESET;
        end else begin
            wr_ack <= wr_go && is_mapped(wr_word);
            rd_ack <= rd_go && is_mapped(rd_word);
            rd_data <= (rd_go && is_mapped(rd_word)) ? rd_mux : '0;
            if (wr_go && wr_word == SCRATCH) begin
                scratch <= wr_data;
            end
        end
    end

    // frame ends seen on each side
    always_ff @(posedge clk) begin
        if (rst || clear_hit) begin
            in_count <= '0;
            in_user <= '0;
            out_count <= '0;
            out_user <= '0;
        end else begin
            if (in_mon.tvalid && in_mon.tready && in_mon.tlast) begin
                in_count <= in_count + 1'b1;
                in_user <= in_mon.tuser;
            end
            if (out_mon.tvalid && out_mon.tready && out_mon.tlast) begin
                out_count <= out_count + 1'b1;
                out_user <= out_mon.tuser;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rbt_send_top.sv
// transmit pipeline top with parser, frame FIFO, sequence stamper, deparser and registers
`default_nettype none
`include "rbt_params.svh"

module rbt_send_top
    import rbt_pkt_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    input  logic [`RBT_DATA_W-1:0]     s_tdata,
    input  logic [`RBT_KEEP_W-1:0]     s_tkeep,
    input  logic                       s_tvalid,
    output logic                       s_tready,
    input  logic                       s_tlast,
    input  logic [`RBT_USER_W-1:0]     s_tuser,

    output logic [`RBT_DATA_W-1:0]     m_tdata,
    output logic [`RBT_KEEP_W-1:0]     m_tkeep,
    output logic                       m_tvalid,
    input  logic                       m_tready,
    output logic                       m_tlast,
    output logic [`RBT_USER_W-1:0]     m_tuser,

    input  logic [`RBT_CSR_ADDR_W-1:0] csr_wr_addr,
    input  logic [`RBT_CSR_DATA_W-1:0] csr_wr_data,
    input  logic                       csr_wr_en,
    output logic                       csr_wr_ack,
    input  logic [`RBT_CSR_ADDR_W-1:0] csr_rd_addr,
    input  logic                       csr_rd_en,
    output logic [`RBT_CSR_DATA_W-1:0] csr_rd_data,
    output logic                       csr_rd_ack
);

    axis_if in_bus ();
    axis_if fifo_in_bus ();
    axis_if fifo_out_bus ();
    axis_if out_bus ();

    rbt_hdr_t psr_hdr;
    logic     psr_hdr_valid;
    logic     psr_hdr_ready;
    rbt_hdr_t stamp_hdr;
    logic     stamp_hdr_valid;
    logic     stamp_hdr_ready;

    assign in_bus.tdata = s_tdata;
    assign in_bus.tkeep = s_tkeep;
    assign in_bus.tvalid = s_tvalid;
    assign in_bus.tlast = s_tlast;
    assign in_bus.tuser = s_tuser;
    assign s_tready = in_bus.tready;

    assign m_tdata = out_bus.tdata;
    assign m_tkeep = out_bus.tkeep;
    assign m_tvalid = out_bus.tvalid;
    assign m_tlast = out_bus.tlast;
    assign m_tuser = out_bus.tuser;
    assign out_bus.tready = m_tready;

    rbt_parser parser_inst (
        .clk       (clk),
        .rst       (rst),
        .in_bus    (in_bus.sink),
        .fifo_bus  (fifo_in_bus.source),
        .hdr       (psr_hdr),
        .hdr_valid (psr_hdr_valid),
        .hdr_ready (psr_hdr_ready)
    );

    rbt_frame_fifo frame_fifo_inst (
        .clk    (clk),
        .rst    (rst),
        .wr_bus (fifo_in_bus.sink),
        .rd_bus (fifo_out_bus.source)
    );

    rbt_seq_stamper stamper_inst (
        .clk       (clk),
        .rst       (rst),
        .in_hdr    (psr_hdr),
        .in_valid  (psr_hdr_valid),
        .in_ready  (psr_hdr_ready),
        .out_hdr   (stamp_hdr),
        .out_valid (stamp_hdr_valid),
        .out_ready (stamp_hdr_ready)
    );

    rbt_deparser deparser_inst (
        .clk       (clk),
        .rst       (rst),
        .fifo_bus  (fifo_out_bus.sink),
        .hdr       (stamp_hdr),
        .hdr_valid (stamp_hdr_valid),
        .hdr_ready (stamp_hdr_ready),
        .out_bus   (out_bus.source)
    );

    rbt_csr_regs csr_regs_inst (
        .clk     (clk),
        .rst     (rst),
        .in_mon  (in_bus.monitor),
        .out_mon (out_bus.monitor),
        .wr_addr (csr_wr_addr),
        .wr_data (csr_wr_data),
        .wr_en   (csr_wr_en),
        .wr_ack  (csr_wr_ack),
        .rd_addr (csr_rd_addr),
        .rd_en   (csr_rd_en),
        .rd_data (csr_rd_data),
        .rd_ack  (csr_rd_ack)
    );

endmodule

`default_nettype wire

// File: testbench/tb_rbt_send.sv
// transmit pipeline testbench with random frames, reference model, register bus checks and watchdog
`default_nettype none
`include "rbt_params.svh"

module tb_rbt_send
    import rbt_pkt_pkg::*;
    import rbt_csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAMES = 200;
    localparam int MAX_BEATS = 6;
    localparam int CLK_PERIOD = 40;
    localparam int SEED = 9646;
    localparam longint TIMEOUT_NS = FRAMES * MAX_BEATS * 4 * CLK_PERIOD + 20000;

    logic                       clk;
    logic                       rst;
    logic [`RBT_DATA_W-1:0]     s_tdata;
    logic [`RBT_KEEP_W-1:0]     s_tkeep;
    logic                       s_tvalid;
    logic                       s_tready;
    logic                       s_tlast;
    logic [`RBT_USER_W-1:0]     s_tuser;
    logic [`RBT_DATA_W-1:0]     m_tdata;
    logic [`RBT_KEEP_W-1:0]     m_tkeep;
    logic                       m_tvalid;
    logic                       m_tready;
    logic                       m_tlast;
    logic [`RBT_USER_W-1:0]     m_tuser;
    logic [`RBT_CSR_ADDR_W-1:0] csr_wr_addr;
    csr_word_t                  csr_wr_data;
    logic                       csr_wr_en;
    logic                       csr_wr_ack;
    logic [`RBT_CSR_ADDR_W-1:0] csr_rd_addr;
    logic                       csr_rd_en;
    csr_word_t                  csr_rd_data;
    logic                       csr_rd_ack;

    // expected output beats in order
    logic [`RBT_DATA_W-1:0]     exp_data_q [$];
    logic [`RBT_KEEP_W-1:0]     exp_keep_q [$];
    logic                       exp_last_q [$];
    logic [`RBT_USER_W-1:0]     exp_user_q [$];
    rbt_hdr_t                   exp_hdr_q [$];
    rbt_seq_t                   model_seq [`RBT_FLOW_COUNT];
    int                         out_frames;
    logic                       out_first;
    logic [`RBT_USER_W-1:0]     last_user;

    rbt_send_top rbt_send_top_inst (
        .clk         (clk),
        .rst         (rst),
        .s_tdata     (s_tdata),
        .s_tkeep     (s_tkeep),
        .s_tvalid    (s_tvalid),
        .s_tready    (s_tready),
        .s_tlast     (s_tlast),
        .s_tuser     (s_tuser),
        .m_tdata     (m_tdata),
        .m_tkeep     (m_tkeep),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser),
        .csr_wr_addr (csr_wr_addr),
        .csr_wr_data (csr_wr_data),
        .csr_wr_en   (csr_wr_en),
        .csr_wr_ack  (csr_wr_ack),
        .csr_rd_addr (csr_rd_addr),
        .csr_rd_en   (csr_rd_en),
        .csr_rd_data (csr_rd_data),
        .csr_rd_ack  (csr_rd_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat(
        input logic [`RBT_DATA_W-1:0] data,
        input logic [`RBT_KEEP_W-1:0] keep,
        input logic                   last,
        input logic [`RBT_USER_W-1:0] user,
        input logic [`RBT_DATA_W-1:0] exp_data,
        input logic [`RBT_KEEP_W-1:0] exp_keep,
        input logic                   exp_last,
        input logic [`RBT_USER_W-1:0] exp_user
    );
        if (data !== exp_data || keep !== exp_keep || last !== exp_last || user !== exp_user) begin
            abort_run($sformatf("Fail at %0t: beat %h/%h/%b/%h, expected %h/%h/%b/%h",
                $time, data, keep, last, user, exp_data, exp_keep, exp_last, exp_user));
        end
    endtask

    task automatic check_hdr(input rbt_hdr_t got, input rbt_hdr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: header flow %h seq %h, expected flow %h seq %h",
                $time, got.flow_id, got.seq, exp.flow_id, exp.seq));
        end
    endtask

    task automatic check_csr(input csr_word_t got, input csr_word_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_beat(
        input logic [`RBT_DATA_W-1:0] data,
        input logic [`RBT_KEEP_W-1:0] keep,
        input logic                   last,
        input logic [`RBT_USER_W-1:0] user
    );
        logic moved;
        s_tdata = data;
        s_tkeep = keep;
        s_tlast = last;
        s_tuser = user;
        s_tvalid = 1'b1;
        moved = 1'b0;
        while (!moved) begin
            @(negedge clk);
            moved = s_tready;
            step_cycle();
        end
        s_tvalid = 1'b0;
    endtask

    task automatic send_frame();
        logic [`RBT_DATA_W-1:0] fdata [MAX_BEATS];
        logic [`RBT_KEEP_W-1:0] fkeep [MAX_BEATS];
        logic [`RBT_USER_W-1:0] user;
        rbt_hdr_t               hdr;
        rbt_hdr_t               stamped;
        rbt_flow_t              flow;
        int                     nbeats;
        nbeats = $urandom_range(1, MAX_BEATS);
        user = 16'($urandom);
        for (int b = 0; b < nbeats; b++) begin
            fdata[b] = {$urandom, $urandom};
            fkeep[b] = (b == nbeats - 1) ? 8'($urandom_range(1, 255)) : 8'hFF;
        end
        hdr = fdata[0];
        // retransmit flag at word bit 8 for about one frame in four
        hdr.flags[0] = ($urandom_range(0, 3) == 0);
        fdata[0] = hdr;
        stamped = hdr;
        flow = hdr.flow_id[3:0];
        if (!hdr.flags[0]) begin
            stamped.seq = model_seq[flow];
            model_seq[flow] = model_seq[flow] + 1'b1;
        end
        exp_hdr_q.push_back(stamped);
        for (int b = 0; b < nbeats; b++) begin
            exp_data_q.push_back((b == 0) ? stamped : fdata[b]);
            exp_keep_q.push_back(fkeep[b]);
            exp_last_q.push_back(b == nbeats - 1);
            exp_user_q.push_back(user);
        end
        for (int b = 0; b < nbeats; b++) begin
            send_beat(fdata[b], fkeep[b], b == nbeats - 1, user);
        end
        last_user = user;
    endtask

    task automatic csr_write(input logic [`RBT_CSR_ADDR_W-1:0] addr, input csr_word_t data);
        csr_wr_addr = addr;
        csr_wr_data = data;
        csr_wr_en = 1'b1;
        @(negedge clk);
        if (csr_wr_ack) abort_run("write ack came before its enable was sampled");
        step_cycle();
        csr_wr_en = 1'b0;
        @(negedge clk);
        if (!csr_wr_ack) abort_run("no write ack one cycle after the enable");
        step_cycle();
    endtask

    task automatic csr_read(input logic [`RBT_CSR_ADDR_W-1:0] addr, output csr_word_t data);
        csr_rd_addr = addr;
        csr_rd_en = 1'b1;
        @(negedge clk);
        if (csr_rd_ack) abort_run("read ack came before its enable was sampled");
        step_cycle();
        csr_rd_en = 1'b0;
        @(negedge clk);
        if (!csr_rd_ack) abort_run("no read ack one cycle after the enable");
        data = csr_rd_data;
        step_cycle();
    endtask

    task automatic csr_read_unmapped(input logic [`RBT_CSR_ADDR_W-1:0] addr);
        csr_rd_addr = addr;
        csr_rd_en = 1'b1;
        step_cycle();
        csr_rd_en = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (csr_rd_ack) abort_run("a read of an unmapped address was acknowledged");
            check_csr(csr_rd_data, '0, "idle read data");
            step_cycle();
        end
    endtask

    task automatic take_output_beat();
        if (exp_data_q.size() == 0) begin
            abort_run("an output beat appeared with no input beat outstanding");
        end else begin
            if (out_first) begin
                check_hdr(rbt_hdr_t'(m_tdata), exp_hdr_q.pop_front());
            end
            check_beat(m_tdata, m_tkeep, m_tlast, m_tuser, exp_data_q.pop_front(),
                exp_keep_q.pop_front(), exp_last_q.pop_front(), exp_user_q.pop_front());
            out_first = m_tlast;
            if (m_tlast) begin
                out_frames++;
            end
        end
    endtask

    // output sink with random back-pressure
    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            m_tready = ($urandom_range(0, 9) < 7);
        end
    end

    // sampled mid-cycle since the beat moves on the next edge
    initial begin
        out_first = 1'b1;
        out_frames = 0;
        forever begin
            @(negedge clk);
            if (!rst && m_tvalid && m_tready) begin
                take_output_beat();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run($sformatf("timeout: the run did not finish within %0d ns", TIMEOUT_NS));
    end

    initial begin
        csr_word_t rd_val;
        csr_word_t scratch_val;
        rst = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = '0;
        csr_wr_addr = '0;
        csr_wr_data = '0;
        csr_wr_en = 1'b0;
        csr_rd_addr = '0;
        csr_rd_en = 1'b0;
        last_user = '0;
        for (int i = 0; i < `RBT_FLOW_COUNT; i++) begin
            model_seq[i] = '0;
        end
        void'($urandom(SEED));
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        csr_read(SCRATCH, rd_val);
        check_csr(rd_val, `RBT_SCRATCH_RESET, "SCRATCH after reset");
        scratch_val = $urandom;
        csr_write(SCRATCH, scratch_val);
        csr_read(SCRATCH, rd_val);
        check_csr(rd_val, scratch_val, "SCRATCH");
        csr_read_unmapped(16'h0020);

        for (int f = 0; f < FRAMES; f++) begin
            repeat ($urandom_range(0, 3)) step_cycle();
            send_frame();
        end
        wait (out_frames == FRAMES);
        step_cycle();

        csr_read(IN_COUNT, rd_val);
        check_csr(rd_val, FRAMES, "IN_COUNT");
        csr_read(OUT_COUNT, rd_val);
        check_csr(rd_val, FRAMES, "OUT_COUNT");
        csr_read(IN_USER, rd_val);
        check_csr(rd_val, {16'h0000, last_user}, "IN_USER");
        csr_read(OUT_USER, rd_val);
        check_csr(rd_val, {16'h0000, last_user}, "OUT_USER");

        csr_write(CLEAR, 32'h1);
        csr_read(IN_COUNT, rd_val);
        check_csr(rd_val, '0, "IN_COUNT after clear");
        csr_read(OUT_COUNT, rd_val);
        check_csr(rd_val, '0, "OUT_COUNT after clear");

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/rbt_pkt_pkg.sv
rtl/rbt_csr_pkg.sv
rtl/axis_if.sv
rtl/rbt_parser.sv
rtl/rbt_frame_fifo.sv
rtl/rbt_seq_stamper.sv
rtl/rbt_deparser.sv
rtl/rbt_csr_regs.sv
rtl/rbt_send_top.sv
testbench/tb_rbt_send.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the transmit pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module tb_rbt_send --Mdir obj_dir > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtb_rbt_send > sim.log 2>&1
grep -q "Regression failed" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Regression passed" sim.log || { echo "Simulation did not finish, see sim.log"; exit 1; }
echo "Simulation passed"
